//--- common/core_consts.svh
// Core sizing constants shared by the decode and execute stages of the integer pipeline
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Width of a register and of every ALU operand and result
`define DATA_WIDTH 16

// Width of a register number in an instruction
`define REG_ADDR_WIDTH 4

// Registers in the file, with register 0 reading as zero
`define NUM_REGS 16

`endif

//--- common/isaPkg.sv
// Instruction set package holding the ALU opcode encoding of the integer core
package isaPkg;

	// Opcodes as carried from issue through ID/EX into the ALU
	typedef enum logic [2:0] {
		OP_ADD = 3'd0, // rs + rt
		OP_SUB = 3'd1, // rs - rt
		OP_AND = 3'd2, // Bitwise and
		OP_OR  = 3'd3, // Bitwise or
		OP_XOR = 3'd4, // Bitwise exclusive or
		OP_SLL = 3'd5, // rs shifted left by the low 4 bits of rt
		OP_LDI = 3'd6  // Result is the immediate, sources ignored
	} aluOp_e;

	// Code 3'd7 is unassigned and makes the ALU return zero

endpackage

//--- common/pipePkg.sv
// Pipeline control package holding the operand source select of the forwarding path
package pipePkg;

	// Select driven by the forwarding unit into each ALU operand mux
	typedef enum logic [1:0] {
		FWD_NONE  = 2'b00, // Take the value read in decode
		FWD_MEMWB = 2'b01, // Take the older result sitting in MEM/WB
		FWD_EXMEM = 2'b10  // Take the newest result sitting in EX/MEM
	} forwardSel_e;

endpackage

//--- design/regFile.sv
// Register file with two combinational read ports, one write port and a write-through bypass
`timescale 1ns/10ps
`include "core_consts.svh"

module regFile (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrA,    // Source of operand A
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrB,    // Source of operand B
	output logic [`DATA_WIDTH-1:0]     rdDataA,
	output logic [`DATA_WIDTH-1:0]     rdDataB,
	input  logic                       wrEn,       // Driven by the write-back valid
	input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`DATA_WIDTH-1:0]     wrData
);

	logic [`DATA_WIDTH-1:0] regs [`NUM_REGS]; // Entry 0 stays zero from reset onward
	logic                   wrLive;           // A write that actually lands this cycle

	assign wrLive = wrEn && (wrAddr != '0); // Writes aimed at register 0 are dropped

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0; // All registers start at zero
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// A reader in the same cycle as the write sees the new data, which closes the
	// gap for a consumer issued three edges after its producer
	assign rdDataA = (rdAddrA == '0)                  ? '0     :
	                 (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0)                  ? '0     :
	                 (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

//--- execute/forwardingUnit.sv
// Forwarding unit that picks the source of each ALU operand from the older pipeline stages
`timescale 1ns/10ps
`include "core_consts.svh"

module forwardingUnit (
	input  logic                       exmemWrite, // EX/MEM holds a valid result
	input  logic                       memwbWrite, // MEM/WB holds a valid result
	input  logic [`REG_ADDR_WIDTH-1:0] exmemRd,
	input  logic [`REG_ADDR_WIDTH-1:0] memwbRd,
	input  logic [`REG_ADDR_WIDTH-1:0] idexRs,     // Source of operand A in ID/EX
	input  logic [`REG_ADDR_WIDTH-1:0] idexRt,     // Source of operand B in ID/EX
	output pipePkg::forwardSel_e       forwardA,
	output pipePkg::forwardSel_e       forwardB
);
	import pipePkg::*;

	logic exHazardA;  // EX/MEM will write operand A's register
	logic exHazardB;  // EX/MEM will write operand B's register
	logic memHazardA; // MEM/WB will write operand A's register
	logic memHazardB; // MEM/WB will write operand B's register

	// Register 0 is excluded since its value is fixed and never produced by a stage
	assign exHazardA  = exmemWrite && (exmemRd != '0) && (exmemRd == idexRs);
	assign exHazardB  = exmemWrite && (exmemRd != '0) && (exmemRd == idexRt);
	assign memHazardA = memwbWrite && (memwbRd != '0) && (memwbRd == idexRs);
	assign memHazardB = memwbWrite && (memwbRd != '0) && (memwbRd == idexRt);

	// The newer stage wins when both older instructions target the same register
	assign forwardA = exHazardA  ? FWD_EXMEM :
	                  memHazardA ? FWD_MEMWB :
	                               FWD_NONE;

	assign forwardB = exHazardB  ? FWD_EXMEM :
	                  memHazardB ? FWD_MEMWB :
	                               FWD_NONE;

endmodule

//--- execute/alu.sv
// Combinational ALU computing the integer opcode set on two operands and an immediate
`timescale 1ns/10ps
`include "core_consts.svh"

module alu (
	input  isaPkg::aluOp_e         op,
	input  logic [`DATA_WIDTH-1:0] a,      // Forwarded rs value
	input  logic [`DATA_WIDTH-1:0] b,      // Forwarded rt value
	input  logic [`DATA_WIDTH-1:0] imm,    // Only consumed by OP_LDI
	output logic [`DATA_WIDTH-1:0] result
);
	import isaPkg::*;

	logic [3:0] shiftAmt; // Only the low bits of rt count for shifts

	assign shiftAmt = b[3:0];

	always_comb begin
		case (op)
			OP_ADD: begin
				result = a + b; // Wraps at the data width
			end
			OP_SUB: begin
				result = a - b;
			end
			OP_AND: begin
				result = a & b;
			end
			OP_OR: begin
				result = a | b;
			end
			OP_XOR: begin
				result = a ^ b;
			end
			OP_SLL: begin
				result = a << shiftAmt; // Zeros shift in from the right
			end
			OP_LDI: begin
				result = imm; // Sources are ignored
			end
			default: begin
				result = '0; // Unassigned opcode
			end
		endcase
	end

endmodule

//--- design/decodeStage.sv
// Decode stage that reads the register file for the issued instruction and loads ID/EX
`timescale 1ns/10ps
`include "core_consts.svh"

module decodeStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issueValid, // One instruction per high cycle
	input  isaPkg::aluOp_e             issueOp,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRd,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRs,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRt,
	input  logic [`DATA_WIDTH-1:0]     issueImm,
	input  logic                       wbValid,    // Write-back from MEM/WB
	input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]     wbData,
	output logic                       idexValid,
	output isaPkg::aluOp_e             idexOp,
	output logic [`REG_ADDR_WIDTH-1:0] idexRd,
	output logic [`REG_ADDR_WIDTH-1:0] idexRs,
	output logic [`REG_ADDR_WIDTH-1:0] idexRt,
	output logic [`DATA_WIDTH-1:0]     idexRsData,
	output logic [`DATA_WIDTH-1:0]     idexRtData,
	output logic [`DATA_WIDTH-1:0]     idexImm
);

	logic [`DATA_WIDTH-1:0] rsData; // Read of the issued rs, bypassed if written now
	logic [`DATA_WIDTH-1:0] rtData; // Read of the issued rt, bypassed if written now

	regFile uRegFile (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (issueRs),
		.rdAddrB (issueRt),
		.rdDataA (rsData),
		.rdDataB (rtData),
		.wrEn    (wbValid),
		.wrAddr  (wbReg),
		.wrData  (wbData)
	);

	// A bubble enters ID/EX as an invalid slot
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idexValid <= 1'b0;
		end else begin
			idexValid <= issueValid;
		end
	end

	// Payload is only meaningful while idexValid is high
	always_ff @(posedge clk) begin
		idexOp     <= issueOp;
		idexRd     <= issueRd;
		idexRs     <= issueRs;
		idexRt     <= issueRt;
		idexRsData <= rsData;
		idexRtData <= rtData;
		idexImm    <= issueImm;
	end

endmodule

//--- execute/executeStage.sv
// Execute stage with forwarded operand muxes, the ALU and the EX/MEM and MEM/WB latches
`timescale 1ns/10ps
`include "core_consts.svh"

module executeStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       idexValid,
	input  isaPkg::aluOp_e             idexOp,
	input  logic [`REG_ADDR_WIDTH-1:0] idexRd,
	input  logic [`REG_ADDR_WIDTH-1:0] idexRs,
	input  logic [`REG_ADDR_WIDTH-1:0] idexRt,
	input  logic [`DATA_WIDTH-1:0]     idexRsData,
	input  logic [`DATA_WIDTH-1:0]     idexRtData,
	input  logic [`DATA_WIDTH-1:0]     idexImm,
	output logic                       wbValid,    // High for one cycle per result
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);
	import pipePkg::*;

	forwardSel_e                forwardA;
	forwardSel_e                forwardB;
	logic [`DATA_WIDTH-1:0]     opA;         // Operand A after forwarding
	logic [`DATA_WIDTH-1:0]     opB;         // Operand B after forwarding
	logic [`DATA_WIDTH-1:0]     aluResult;
	logic                       exmemValid;
	logic [`REG_ADDR_WIDTH-1:0] exmemRd;
	logic [`DATA_WIDTH-1:0]     exmemResult;
	logic                       memwbValid;
	logic [`REG_ADDR_WIDTH-1:0] memwbRd;
	logic [`DATA_WIDTH-1:0]     memwbResult;

	// Same mux for both operands
	function automatic logic [`DATA_WIDTH-1:0] pickOperand(
		input forwardSel_e            sel,
		input logic [`DATA_WIDTH-1:0] regData,
		input logic [`DATA_WIDTH-1:0] exmemData,
		input logic [`DATA_WIDTH-1:0] memwbData
	);
		case (sel)
			FWD_EXMEM: return exmemData;
			FWD_MEMWB: return memwbData;
			default:   return regData;
		endcase
	endfunction

	forwardingUnit uForward (
		.exmemWrite (exmemValid), // Bubbles never forward
		.memwbWrite (memwbValid),
		.exmemRd    (exmemRd),
		.memwbRd    (memwbRd),
		.idexRs     (idexRs),
		.idexRt     (idexRt),
		.forwardA   (forwardA),
		.forwardB   (forwardB)
	);

	assign opA = pickOperand(forwardA, idexRsData, exmemResult, memwbResult);
	assign opB = pickOperand(forwardB, idexRtData, exmemResult, memwbResult);

	alu uAlu (
		.op     (idexOp),
		.a      (opA),
		.b      (opB),
		.imm    (idexImm),
		.result (aluResult)
	);

	// Valid bits walk the slot down the pipe, bubbles included
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exmemValid <= 1'b0;
			memwbValid <= 1'b0;
		end else begin
			exmemValid <= idexValid;
			memwbValid <= exmemValid;
		end
	end

	// The memory stage has no work and just holds the result a cycle
	always_ff @(posedge clk) begin
		exmemRd     <= idexRd;
		exmemResult <= aluResult;
		memwbRd     <= exmemRd;
		memwbResult <= exmemResult;
	end

	assign wbValid = memwbValid;
	assign wbReg   = memwbRd;
	assign wbData  = memwbResult;

endmodule

//--- design/pipeTop.sv
// Integer pipeline top joining decode and execute, with write-back looped into the register file
`timescale 1ns/10ps
`include "core_consts.svh"

module pipeTop (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issueValid,
	input  isaPkg::aluOp_e             issueOp,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRd,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRs,
	input  logic [`REG_ADDR_WIDTH-1:0] issueRt,
	input  logic [`DATA_WIDTH-1:0]     issueImm,
	output logic                       wbValid,  // Result leaves three edges after issue
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);
	import isaPkg::*;

	logic                       idexValid;
	aluOp_e                     idexOp;
	logic [`REG_ADDR_WIDTH-1:0] idexRd;
	logic [`REG_ADDR_WIDTH-1:0] idexRs;
	logic [`REG_ADDR_WIDTH-1:0] idexRt;
	logic [`DATA_WIDTH-1:0]     idexRsData;
	logic [`DATA_WIDTH-1:0]     idexRtData;
	logic [`DATA_WIDTH-1:0]     idexImm;

	decodeStage uDecode (
		.clk (clk), .rstN (rstN),
		.issueValid (issueValid), .issueOp (issueOp), .issueRd (issueRd),
		.issueRs (issueRs), .issueRt (issueRt), .issueImm (issueImm),
		.wbValid (wbValid), .wbReg (wbReg), .wbData (wbData), // Write-back loop
		.idexValid (idexValid), .idexOp (idexOp), .idexRd (idexRd),
		.idexRs (idexRs), .idexRt (idexRt), .idexRsData (idexRsData),
		.idexRtData (idexRtData), .idexImm (idexImm)
	);

	executeStage uExecute (
		.clk (clk), .rstN (rstN),
		.idexValid (idexValid), .idexOp (idexOp), .idexRd (idexRd),
		.idexRs (idexRs), .idexRt (idexRt), .idexRsData (idexRsData),
		.idexRtData (idexRtData), .idexImm (idexImm),
		.wbValid (wbValid), .wbReg (wbReg), .wbData (wbData)
	);

endmodule

//--- tb/pipe_assertions.sv
// Concurrent checks on the forwarding selects and on write-back during reset
`timescale 1ns/10ps
`include "core_consts.svh"

module pipeAssertions (
	input logic                       clk,
	input logic                       rstN,
	input logic                       wbValid,
	input logic [`REG_ADDR_WIDTH-1:0] exmemRd,
	input logic [`REG_ADDR_WIDTH-1:0] idexRs,
	input logic [`REG_ADDR_WIDTH-1:0] idexRt,
	input pipePkg::forwardSel_e       forwardA,
	input pipePkg::forwardSel_e       forwardB
);
	import pipePkg::*;

	aZeroSrcA: assert property (@(posedge clk) disable iff (!rstN)
		(forwardA != FWD_NONE) |-> (idexRs != '0)) // Register 0 is never forwarded
		else $error("Operand A forwarded with register 0 as its source");
	aZeroSrcB: assert property (@(posedge clk) disable iff (!rstN)
		(forwardB != FWD_NONE) |-> (idexRt != '0))
		else $error("Operand B forwarded with register 0 as its source");
	aExmemA: assert property (@(posedge clk) disable iff (!rstN)
		(forwardA == FWD_EXMEM) |-> (exmemRd == idexRs))
		else $error("Operand A took EX/MEM for a different register");
	aExmemB: assert property (@(posedge clk) disable iff (!rstN)
		(forwardB == FWD_EXMEM) |-> (exmemRd == idexRt))
		else $error("Operand B took EX/MEM for a different register");
	aResetQuiet: assert property (@(posedge clk) !rstN |-> !wbValid) // Nothing leaves in reset
		else $error("Write-back valid while reset is held");

endmodule

// The execute stage holds both the forwarding connections and the write-back valid
bind executeStage pipeAssertions uAssert (
	.clk (clk), .rstN (rstN), .wbValid (wbValid), .exmemRd (exmemRd),
	.idexRs (idexRs), .idexRt (idexRt), .forwardA (forwardA), .forwardB (forwardB)
);

//--- tb/pipe_tb.sv
// Testbench for the integer pipeline that runs instruction tables against a register model
`timescale 1ns/10ps
`include "core_consts.svh"

module pipe_tb;
	import isaPkg::*;

	localparam int MaxInstr = 48;
	localparam int MaxTests = 8;

	typedef struct packed {
		logic [31:0]                due;   // Monitor cycle on which the result must show
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0]     value;
	} wbEntry_t;

	logic                       clk = 1'b0;
	logic                       rstN;
	logic                       issueValid;
	aluOp_e                     issueOp;
	logic [`REG_ADDR_WIDTH-1:0] issueRd;
	logic [`REG_ADDR_WIDTH-1:0] issueRs;
	logic [`REG_ADDR_WIDTH-1:0] issueRt;
	logic [`DATA_WIDTH-1:0]     issueImm;
	logic                       wbValid;
	logic [`REG_ADDR_WIDTH-1:0] wbReg;
	logic [`DATA_WIDTH-1:0]     wbData;

	string                      testName [MaxTests];
	int                         testFirst [MaxTests]; // First table row of each test
	int                         testLen [MaxTests];
	aluOp_e                     tOp [MaxInstr];
	logic [`REG_ADDR_WIDTH-1:0] tRd [MaxInstr];
	logic [`REG_ADDR_WIDTH-1:0] tRs [MaxInstr];
	logic [`REG_ADDR_WIDTH-1:0] tRt [MaxInstr];
	logic [`DATA_WIDTH-1:0]     tImm [MaxInstr];
	logic [`DATA_WIDTH-1:0]     tExp [MaxInstr];      // Expected wbData from the model
	int                         tGap [MaxInstr];      // Bubbles issued before the row
	logic [`DATA_WIDTH-1:0]     modelRegs [`NUM_REGS]; // Architectural state in issue order
	int                         numTests = 0;
	int                         numInstr = 0;
	logic [31:0]                lcgState = 32'd39;
	wbEntry_t                   expQ [$];             // Results still owed by the DUT
	int                         cycles = 0;
	int                         cycleLimit = 100000;  // Replaced once the table is built
	int                         errors = 0;
	string                      curTest = "reset";

	pipeTop dut_i (.*);

	always #50 clk = ~clk; // 100 ns period

	function automatic logic [`DATA_WIDTH-1:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16]; // Upper bits have the longest period
	endfunction

	// Opcode rules of the instruction set
	function automatic logic [`DATA_WIDTH-1:0] applyRule(input aluOp_e op,
		input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b,
		input logic [`DATA_WIDTH-1:0] imm);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLL:  return a << b[3:0];
			OP_LDI:  return imm;
			default: return '0;
		endcase
	endfunction

	task automatic beginTest(input string name);
		testName[numTests] = name;
		testFirst[numTests] = numInstr;
		testLen[numTests] = 0;
		numTests++;
	endtask

	// Adds one row and runs it through the model so the row carries its expected result
	task automatic addInstr(input aluOp_e op, input int rd, input int rs, input int rt,
		input int gap);
		logic [`DATA_WIDTH-1:0] imm;
		imm = (op == OP_LDI) ? nextRand() : 16'hFFFF; // Non-LDI immediates must be ignored
		tOp[numInstr] = op;
		tRd[numInstr] = rd[3:0];
		tRs[numInstr] = rs[3:0];
		tRt[numInstr] = rt[3:0];
		tImm[numInstr] = imm;
		tGap[numInstr] = gap;
		tExp[numInstr] = applyRule(op, modelRegs[rs[3:0]], modelRegs[rt[3:0]], imm);
		if (rd != 0) begin
			modelRegs[rd[3:0]] = tExp[numInstr]; // Register 0 stays zero in the model
		end
		testLen[numTests - 1]++;
		numInstr++;
	endtask

	task automatic buildTable();
		for (int r = 0; r < `NUM_REGS; r++) begin
			modelRegs[r] = '0;
		end
		beginTest("opcodes");
		addInstr(OP_LDI, 1, 0, 0, 0);
		addInstr(OP_LDI, 2, 0, 0, 0);
		addInstr(OP_ADD, 3, 1, 2, 4); // Far enough to read stored registers
		addInstr(OP_SUB, 4, 1, 2, 0);
		addInstr(OP_AND, 5, 1, 2, 0);
		addInstr(OP_OR, 6, 1, 2, 0);
		addInstr(OP_XOR, 7, 1, 2, 0);
		addInstr(OP_SLL, 8, 1, 2, 0);
		beginTest("fwdExmem");
		addInstr(OP_LDI, 9, 0, 0, 0);
		addInstr(OP_ADD, 10, 9, 1, 0); // rs straight from EX/MEM
		addInstr(OP_LDI, 11, 0, 0, 0);
		addInstr(OP_SUB, 12, 2, 11, 0); // rt straight from EX/MEM
		beginTest("fwdMemwbBypass");
		addInstr(OP_LDI, 3, 0, 0, 0);
		addInstr(OP_ADD, 13, 3, 3, 1); // One bubble puts the producer in MEM/WB
		addInstr(OP_LDI, 4, 0, 0, 0);
		addInstr(OP_OR, 14, 1, 4, 2); // Two bubbles leave only the regFile bypass
		addInstr(OP_LDI, 5, 0, 0, 0);
		addInstr(OP_LDI, 6, 0, 0, 0);
		addInstr(OP_AND, 7, 5, 6, 0); // r5 from MEM/WB and r6 from EX/MEM
		addInstr(OP_LDI, 8, 0, 0, 0);
		addInstr(OP_ADD, 9, 1, 1, 0);
		addInstr(OP_XOR, 10, 2, 2, 0);
		addInstr(OP_SLL, 11, 8, 2, 0); // r8 through the bypass without bubbles
		addInstr(OP_ADD, 12, 8, 1, 0); // r8 now stored
		beginTest("newestWins");
		addInstr(OP_LDI, 5, 0, 0, 0);
		addInstr(OP_LDI, 5, 0, 0, 0);
		addInstr(OP_ADD, 6, 5, 5, 0); // Both stages hold r5 and the newer one counts
		addInstr(OP_SUB, 7, 5, 6, 0);
		beginTest("regZero");
		addInstr(OP_LDI, 0, 0, 0, 0); // Shows on write-back but never lands
		addInstr(OP_ADD, 1, 0, 2, 0);
		addInstr(OP_OR, 3, 0, 0, 0);
		addInstr(OP_XOR, 4, 0, 2, 0);
		addInstr(OP_ADD, 5, 0, 0, 2);
		beginTest("bubbles");
		addInstr(OP_LDI, 12, 0, 0, 0);
		addInstr(OP_ADD, 13, 12, 1, 2); // Stale bubbles in front claim r12
		addInstr(OP_LDI, 14, 0, 0, 0);
		addInstr(OP_SUB, 15, 14, 2, 3);
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH test %s %s expected %0h actual %0h", curTest, what,
				expected, actual);
		end
	endtask

	// Outputs are sampled mid-cycle, away from the edge that updates them
	always @(negedge clk) begin
		wbEntry_t head;
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles with %0d results outstanding", cycles,
				expQ.size());
			$display("Simulation finished: FAIL");
			$finish;
		end else if (wbValid === 1'b1) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Test %s wrote r%0d back with no instruction in flight", curTest, wbReg);
			end else begin
				head = expQ.pop_front();
				checkValue("wbReg", 32'(head.rd), 32'(wbReg));
				checkValue("wbData", 32'(head.value), 32'(wbData));
				checkValue("cycle", head.due, 32'(cycles)); // Three edges after issue
			end
		end else if (expQ.size() != 0 && expQ[0].due <= 32'(cycles)) begin
			errors++;
			$display("Test %s never wrote r%0d back", curTest, expQ[0].rd);
			void'(expQ.pop_front());
		end
	end

	initial begin
		int failsBefore;
		int bubbles;
		rstN = 1'b0;
		issueValid = 1'b0;
		issueOp = OP_ADD;
		issueRd = '0;
		issueRs = '0;
		issueRt = '0;
		issueImm = '0;
		buildTable();
		bubbles = 0;
		for (int i = 0; i < numInstr; i++) begin
			bubbles += tGap[i];
		end
		cycleLimit = 8 + numInstr + bubbles + 4 * numTests + 20; // Reset, issue and drain
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		for (int t = 0; t < numTests; t++) begin
			curTest = testName[t];
			failsBefore = errors;
			for (int i = testFirst[t]; i < testFirst[t] + testLen[t]; i++) begin
				repeat (tGap[i]) begin
					@(posedge clk);
					issueValid <= 1'b0;
					issueOp <= OP_LDI;
					issueRd <= tRs[i];  // Bubble poses as a writer of the next source
					issueImm <= 16'hDEAD;
				end
				@(posedge clk);
				issueValid <= 1'b1;
				issueOp <= tOp[i];
				issueRd <= tRd[i];
				issueRs <= tRs[i];
				issueRt <= tRt[i];
				issueImm <= tImm[i];
				expQ.push_back({32'(cycles + 4), tRd[i], tExp[i]});
			end
			@(posedge clk);
			issueValid <= 1'b0;
			while (expQ.size() != 0) begin
				@(posedge clk);
			end
			$display("Test %s: %s", curTest, (errors == failsBefore) ? "ok" : "errors found");
		end
		$display("Tests %0d, instructions %0d, errors %0d", numTests, numInstr, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
design/regFile.sv
execute/forwardingUnit.sv
execute/alu.sv
design/decodeStage.sv
execute/executeStage.sv
design/pipeTop.sv
tb/pipe_assertions.sv
tb/pipe_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' src.f) common/core_consts.svh

.PHONY: run clean

obj_dir/Vpipe_tb: src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps -f src.f \
		--top-module pipe_tb -o Vpipe_tb

run: obj_dir/Vpipe_tb
	./obj_dir/Vpipe_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
